// File: src/csr_index_macros.svh
// ----------------------------------------------------------------------
// Width, lane and queue size constants for the stride index configurator.
// Included by the package and by every module that sizes a port.
// ----------------------------------------------------------------------
`ifndef CSR_INDEX_MACROS_SVH
`define CSR_INDEX_MACROS_SVH

`define CSR_DATA_W      32
`define CSR_OFFSET_W    16
`define CSR_SHIFT_W     4
`define CSR_SEQ_WIDTH   16
`define CSR_LANES       4
`define CSR_LANE_W      2
`define CSR_ADDR_W      64
`define CSR_FIFO_DEPTH  16
`define CSR_PROG_THRESH 12
`define CSR_CMD_W       3
`define CSR_BUF_W       3

`endif

// File: src/csr_index_pkg.sv
// ----------------------------------------------------------------------
// Shared types for the configurator: response and lane buses, the
// decoded configuration record and the two-view configuration word.
// ----------------------------------------------------------------------
`default_nettype none
`include "csr_index_macros.svh"

package csr_index_pkg;

    typedef enum logic [`CSR_BUF_W-1:0] {
        BUF_INVALID      = 3'd0,
        BUF_CU_SETUP     = 3'd1,
        BUF_ENGINE_SETUP = 3'd2,
        BUF_KERNEL_DATA  = 3'd3,
        BUF_VERTEX_DATA  = 3'd4,
        BUF_EDGE_DATA    = 3'd5
    } buffer_type_e;

    typedef enum logic [`CSR_CMD_W-1:0] {
        CMD_INVALID      = 3'd0,
        CMD_MEM_READ     = 3'd1,
        CMD_MEM_WRITE    = 3'd2,
        CMD_STREAM_READ  = 3'd3,
        CMD_STREAM_WRITE = 3'd4,
        CMD_CONFIGURE    = 3'd5
    } memory_cmd_e;

    typedef struct packed {
        logic                     valid;
        buffer_type_e             buffer;
        logic [`CSR_OFFSET_W-1:0] offset;
        logic [`CSR_SHIFT_W-1:0]  shift;
        logic [`CSR_DATA_W-1:0]   data;
    } memory_response_t;

    typedef struct packed {
        logic                               valid;
        logic [$clog2(`CSR_SEQ_WIDTH)-1:0]  seq;
        logic [`CSR_DATA_W-1:0]             data;
    } lane_word_t;

    // Word 0 carries the mode flags, word 4 the granularity and direction
    typedef union packed {
        logic [`CSR_DATA_W-1:0] raw;
        struct packed {
            logic [`CSR_DATA_W-5:0] reserved;
            logic                   mode_buffer;
            logic                   mode_sequence;
            logic                   decrement;
            logic                   increment;
        } mode;
        struct packed {
            logic                   direction;
            logic [`CSR_DATA_W-2:0] granularity;
        } shift;
    } config_word_u;

    typedef struct packed {
        logic                   increment;
        logic                   decrement;
        logic                   mode_sequence;
        logic                   mode_buffer;
        logic [`CSR_DATA_W-1:0] index_start;
        logic [`CSR_DATA_W-1:0] index_end;
        logic [`CSR_DATA_W-1:0] stride;
        logic [`CSR_DATA_W-1:0] array_size;
        logic [`CSR_DATA_W-2:0] granularity;
        logic                   direction;
        memory_cmd_e            cmd;
        buffer_type_e           buffer;
        logic [`CSR_ADDR_W-1:0] array_pointer;
    } index_config_t;

    typedef struct packed {
        logic                   valid;
        logic [`CSR_LANE_W-1:0] lane;
        index_config_t          index_config;
    } config_record_t;

endpackage

`default_nettype wire

// File: src/sync_fifo.sv
// ----------------------------------------------------------------------
// Show-ahead synchronous FIFO with an almost-full flag. The head word is
// on dout whenever empty is low; rd_en pops it on the next edge.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "csr_index_macros.svh"

module sync_fifo #(
    parameter int DEPTH = `CSR_FIFO_DEPTH,
    parameter int WIDTH = 8
) (
    input  logic             ap_clk,
    input  logic             areset_csr_index_generator,
    input  logic [WIDTH-1:0] din,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign push = wr_en & ~full;
    assign pop  = rd_en & ~empty;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            // Count moves only when one side is active alone
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push)
            mem[wr_ptr] <= din;
    end

    assign dout      = mem[rd_ptr];
    assign empty     = (count == '0);
    assign full      = (count == (PTR_W+1)'(DEPTH));
    assign prog_full = (count >= (PTR_W+1)'(`CSR_PROG_THRESH));

endmodule

`default_nettype wire

// File: src/config_response_dispatcher.sv
// ----------------------------------------------------------------------
// Filters memory read responses down to setup traffic inside the lane
// windows, queues them, and hands the queue head to its target lane.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "csr_index_macros.svh"

module config_response_dispatcher import csr_index_pkg::*; (
    input  logic                    ap_clk,
    input  logic                    areset_csr_index_generator,
    input  memory_response_t        response,
    input  logic [`CSR_LANES-1:0]   lane_busy,
    output logic                    in_prog_full,
    output lane_word_t              lane_word,
    output logic [`CSR_LANES-1:0]   lane_select
);

    localparam int POS_W     = $clog2(`CSR_SEQ_WIDTH);
    localparam int SEQ_LIMIT = `CSR_LANES * `CSR_SEQ_WIDTH;

    memory_response_t         resp_reg;
    memory_response_t         head;
    logic [`CSR_OFFSET_W-1:0] resp_seq;
    logic [`CSR_OFFSET_W-1:0] head_seq;
    logic [`CSR_LANE_W-1:0]   head_lane;
    logic                     setup_type;
    logic                     wr_en;
    logic                     pop;
    logic                     empty;
    logic                     full;

// ----------------------------------------------------------------------
// Input register and filter
// ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        resp_reg.buffer <= response.buffer;
        resp_reg.offset <= response.offset;
        resp_reg.shift  <= response.shift;
        resp_reg.data   <= response.data;
        if (areset_csr_index_generator)
            resp_reg.valid <= 1'b0;
        else
            resp_reg.valid <= response.valid;
    end

    // Sequence number is the word offset scaled down by the shift
    assign resp_seq   = resp_reg.offset >> resp_reg.shift;
    assign setup_type = (resp_reg.buffer == BUF_CU_SETUP) ||
                        (resp_reg.buffer == BUF_ENGINE_SETUP);
    assign wr_en      = resp_reg.valid & setup_type & (resp_seq < SEQ_LIMIT);

    sync_fifo #(
        .DEPTH (`CSR_FIFO_DEPTH),
        .WIDTH ($bits(memory_response_t))
    ) i_input_fifo (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .din                        (resp_reg),
        .wr_en                      (wr_en),
        .rd_en                      (pop),
        .dout                       (head),
        .empty                      (empty),
        .full                       (full),
        .prog_full                  (in_prog_full)
    );

// ----------------------------------------------------------------------
// Head decode and lane hand-off
// ----------------------------------------------------------------------
    assign head_seq  = head.offset >> head.shift;
    assign head_lane = head_seq[POS_W +: `CSR_LANE_W];

    // A finished lane blocks the whole queue until it is drained
    assign pop = ~empty & ~lane_busy[head_lane];

    assign lane_word.valid = pop;
    assign lane_word.seq   = head_seq[POS_W-1:0];
    assign lane_word.data  = head.data;
    assign lane_select     = pop ? (`CSR_LANES)'(1) << head_lane : '0;

    // Upstream must honour in_prog_full well before the queue fills
    assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        !(wr_en && full))
        else $error("Response written into a full input queue");

endmodule

`default_nettype wire

// File: src/config_word_capture.sv
// ----------------------------------------------------------------------
// One lane's record assembly. Words arrive in any order by sequence
// position; busy marks a complete record until the collector grants it.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "csr_index_macros.svh"

module config_word_capture import csr_index_pkg::*; #(
    parameter int LANE_ID = 0
) (
    input  logic          ap_clk,
    input  logic          areset_csr_index_generator,
    input  lane_word_t    lane_word,
    input  logic          select,
    input  logic          grant,
    output logic          busy,
    output index_config_t index_config
);

    logic [`CSR_SEQ_WIDTH-1:0] present;
    config_word_u              word;
    logic                      store;

    assign word.raw = lane_word.data;
    assign store    = select & lane_word.valid;

    // Complete once every position has been seen at least once
    assign busy = &present;

// ----------------------------------------------------------------------
// Presence mask
// ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator)
            present <= '0;
        else if (grant)
            present <= '0;
        else if (store)
            present[lane_word.seq] <= 1'b1;
    end

// ----------------------------------------------------------------------
// Field decode by position
// ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (store) begin
            case (lane_word.seq)
                4'd0: begin
                    index_config.increment     <= word.mode.increment;
                    index_config.decrement     <= word.mode.decrement;
                    index_config.mode_sequence <= word.mode.mode_sequence;
                    index_config.mode_buffer   <= word.mode.mode_buffer;
                end
                4'd1: index_config.index_start <= word.raw;
                4'd2: index_config.index_end   <= word.raw;
                4'd3: index_config.stride      <= word.raw;
                4'd4: begin
                    index_config.granularity <= word.shift.granularity;
                    index_config.direction   <= word.shift.direction;
                end
                4'd5: begin
                    index_config.cmd    <= memory_cmd_e'(word.raw[`CSR_CMD_W-1:0]);
                    index_config.buffer <= buffer_type_e'(word.raw[`CSR_CMD_W +: `CSR_BUF_W]);
                end
                // Pointer is split low word first
                4'd8: index_config.array_pointer[`CSR_DATA_W-1:0] <= word.raw;
                4'd9: index_config.array_pointer[`CSR_ADDR_W-1:`CSR_DATA_W] <= word.raw;
                4'd10: index_config.array_size <= word.raw;
                default: begin
                    // Presence only
                end
            endcase
        end
    end

    // Dispatcher must hold words back while the record waits for a grant
    assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        select |-> !busy)
        else $error("Lane %0d selected while holding a finished record", LANE_ID);

endmodule

`default_nettype wire

// File: src/config_collector.sv
// ----------------------------------------------------------------------
// Round-robin drain of finished lanes into the show-ahead output queue.
// Grants stop while the queue is almost full.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "csr_index_macros.svh"

module config_collector import csr_index_pkg::*; (
    input  logic                  ap_clk,
    input  logic                  areset_csr_index_generator,
    input  logic [`CSR_LANES-1:0] lane_busy,
    input  index_config_t         lane_config [`CSR_LANES],
    output logic [`CSR_LANES-1:0] grant,
    output config_record_t        config_out,
    input  logic                  config_rd_en
);

    localparam int LANE_W = `CSR_LANE_W;

    logic [LANE_W-1:0] last_lane;
    logic [LANE_W-1:0] cand;
    logic [LANE_W-1:0] pick;
    logic              found;
    logic              allow;
    config_record_t    record_in;
    config_record_t    head;
    logic              empty;
    logic              full;
    logic              prog_full;

// ----------------------------------------------------------------------
// Arbiter
// ----------------------------------------------------------------------
    // Search starts one past the last granted lane and wraps
    always_comb begin
        found = 1'b0;
        pick  = last_lane;
        cand  = last_lane;
        for (int i = 1; i <= `CSR_LANES; i++) begin
            cand = last_lane + LANE_W'(i);
            if (!found && lane_busy[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    assign allow = ~prog_full;
    assign grant = (found && allow) ? (`CSR_LANES)'(1) << pick : '0;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator)
            last_lane <= '0;
        else if (|grant)
            last_lane <= pick;
    end

    assign record_in.valid        = 1'b1;
    assign record_in.lane         = pick;
    assign record_in.index_config = lane_config[pick];

    sync_fifo #(
        .DEPTH (`CSR_FIFO_DEPTH),
        .WIDTH ($bits(config_record_t))
    ) i_output_fifo (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .din                        (record_in),
        .wr_en                      (|grant),
        .rd_en                      (config_rd_en),
        .dout                       (head),
        .empty                      (empty),
        .full                       (full),
        .prog_full                  (prog_full)
    );

    always_comb begin
        config_out       = head;
        config_out.valid = ~empty;
    end

    // Almost-full has to cut grants before the queue runs out of room
    assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        !(|grant && full))
        else $error("Record written into a full output queue");

endmodule

`default_nettype wire

// File: src/csr_index_configure_top.sv
// ----------------------------------------------------------------------
// Top level of the four-lane stride index configurator. Takes memory
// responses and yields complete configuration records, one per pop.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "csr_index_macros.svh"

module csr_index_configure_top import csr_index_pkg::*; (
    input  logic             ap_clk,
    input  logic             areset_csr_index_generator,
    input  memory_response_t response,
    output logic             in_prog_full,
    output config_record_t   config_out,
    input  logic             config_rd_en
);

    lane_word_t            lane_word;
    logic [`CSR_LANES-1:0] lane_select;
    logic [`CSR_LANES-1:0] lane_busy;
    logic [`CSR_LANES-1:0] grant;
    index_config_t         lane_config [`CSR_LANES];

    config_response_dispatcher i_dispatcher (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .response                   (response),
        .lane_busy                  (lane_busy),
        .in_prog_full               (in_prog_full),
        .lane_word                  (lane_word),
        .lane_select                (lane_select)
    );

    for (genvar g = 0; g < `CSR_LANES; g++) begin : g_lane
        config_word_capture #(
            .LANE_ID (g)
        ) i_capture (
            .ap_clk                     (ap_clk),
            .areset_csr_index_generator (areset_csr_index_generator),
            .lane_word                  (lane_word),
            .select                     (lane_select[g]),
            .grant                      (grant[g]),
            .busy                       (lane_busy[g]),
            .index_config               (lane_config[g])
        );
    end

    config_collector i_collector (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .lane_busy                  (lane_busy),
        .lane_config                (lane_config),
        .grant                      (grant),
        .config_out                 (config_out),
        .config_rd_en               (config_rd_en)
    );

endmodule

`default_nettype wire

// File: testbench/tb_csr_index_tasks.svh
// ----------------------------------------------------------------------
// Testbench helpers and directed tests, included inside the testbench
// top: LFSR, value check, bus drivers, the record model and the tests.
// ----------------------------------------------------------------------
`ifndef TB_CSR_INDEX_TASKS_SVH
`define TB_CSR_INDEX_TASKS_SVH

localparam int WAIT_LIMIT = 2000;

logic [31:0]            lfsr_state = 32'haac2;
logic [`CSR_DATA_W-1:0] lane_words [`CSR_LANES][`CSR_SEQ_WIDTH];

// Galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit)
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    return out_bit;
endfunction

function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = '0;
    for (int b = 0; b < 32; b++)
        w = {w[30:0], lfsr_bit()};
    return w;
endfunction

task automatic fail_run(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "Simulation stopped");
endtask

task automatic check_value(input string test_name, input logic [255:0] expected,
                           input logic [255:0] actual);
    if (expected !== actual)
        fail_run($sformatf("** Error [%s] expected %h, actual %h",
                           test_name, expected, actual));
endtask

// ----------------------------------------------------------------------
// Reference model of one lane's record
// ----------------------------------------------------------------------
function automatic index_config_t expected_config(input int lane);
    index_config_t cfg;
    cfg               = '0;
    cfg.increment     = lane_words[lane][0][0];
    cfg.decrement     = lane_words[lane][0][1];
    cfg.mode_sequence = lane_words[lane][0][2];
    cfg.mode_buffer   = lane_words[lane][0][3];
    cfg.index_start   = lane_words[lane][1];
    cfg.index_end     = lane_words[lane][2];
    cfg.stride        = lane_words[lane][3];
    cfg.granularity   = lane_words[lane][4][30:0];
    cfg.direction     = lane_words[lane][4][31];
    cfg.cmd           = memory_cmd_e'(lane_words[lane][5][2:0]);
    cfg.buffer        = buffer_type_e'(lane_words[lane][5][5:3]);
    cfg.array_size    = lane_words[lane][10];
    cfg.array_pointer = {lane_words[lane][9], lane_words[lane][8]};
    return cfg;
endfunction

function automatic void fill_pattern(input int lane, input int salt);
    for (int pos = 0; pos < `CSR_SEQ_WIDTH; pos++)
        lane_words[lane][pos] = {8'(salt), 8'(lane), 8'(pos), 8'(salt * 37 + lane * 16 + pos)};
endfunction

// ----------------------------------------------------------------------
// Bus drivers
// ----------------------------------------------------------------------
task automatic drive_response(input buffer_type_e buffer, input logic [15:0] offset,
                              input logic [3:0] shift, input logic [31:0] data);
    memory_response_t word;
    int               waited;
    word.valid  = 1'b1;
    word.buffer = buffer;
    word.offset = offset;
    word.shift  = shift;
    word.data   = data;
    waited      = 0;
    @(negedge ap_clk);
    while (in_prog_full) begin
        @(posedge ap_clk);
        response.valid <= 1'b0;
        @(negedge ap_clk);
        waited++;
        if (waited > WAIT_LIMIT)
            fail_run("Timed out waiting for in_prog_full to drop");
    end
    @(posedge ap_clk);
    response <= word;
endtask

task automatic end_burst();
    @(posedge ap_clk);
    response.valid <= 1'b0;
endtask

task automatic send_lane_word(input int lane, input int pos, input int shift,
                              input buffer_type_e buffer);
    drive_response(buffer, 16'((lane * `CSR_SEQ_WIDTH + pos) << shift), 4'(shift),
                   lane_words[lane][pos]);
endtask

task automatic get_record(output config_record_t rec);
    int waited;
    waited = 0;
    @(negedge ap_clk);
    while (!config_out.valid) begin
        @(negedge ap_clk);
        waited++;
        if (waited > WAIT_LIMIT)
            fail_run("Timed out waiting for a configuration record");
    end
    rec = config_out;
    @(posedge ap_clk);
    config_rd_en <= 1'b1;
    @(posedge ap_clk);
    config_rd_en <= 1'b0;
endtask

// Records may come out in any lane order
task automatic collect_records(input logic [3:0] lanes, input string test_name);
    config_record_t rec;
    logic [3:0]     pending;
    pending = lanes;
    while (pending != '0) begin
        get_record(rec);
        if (!pending[rec.lane])
            fail_run($sformatf("%s: unexpected record from lane %0d", test_name, rec.lane));
        pending[rec.lane] = 1'b0;
        check_value(test_name, expected_config(rec.lane), rec.index_config);
    end
endtask

task automatic expect_idle(input int cycles, input string test_name);
    repeat (cycles) begin
        @(negedge ap_clk);
        check_value(test_name, 0, config_out.valid);
    end
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------
task automatic test_reset_idle();
    @(negedge ap_clk);
    check_value("reset_idle", 0, config_out.valid);
    check_value("reset_idle", 0, in_prog_full);
    expect_idle(50, "reset_idle");
endtask

task automatic test_lane0_in_order();
    fill_pattern(0, 2);
    lane_words[0][0] = 32'h0000_0005;
    lane_words[0][4] = 32'h8000_0040;
    lane_words[0][5] = {26'd0, BUF_ENGINE_SETUP, CMD_CONFIGURE};
    lane_words[0][8] = 32'h89AB_CDEF;
    lane_words[0][9] = 32'h0000_0012;
    for (int pos = 0; pos < `CSR_SEQ_WIDTH; pos++)
        send_lane_word(0, pos, 0, BUF_CU_SETUP);
    end_burst();
    collect_records(4'b0001, "lane0_in_order");
    expect_idle(30, "lane0_in_order");
endtask

task automatic test_lane2_shuffled();
    fill_pattern(2, 3);
    // Early stale value for position 9, overwritten later in the set
    drive_response(BUF_ENGINE_SETUP, 16'((2 * 16 + 9) << 2), 4'd2, 32'hDEAD_0009);
    for (int i = 0; i < `CSR_SEQ_WIDTH; i++)
        send_lane_word(2, (i * 7 + 3) % 16, 2, BUF_ENGINE_SETUP);
    end_burst();
    collect_records(4'b0100, "lane2_shuffled");
    expect_idle(20, "lane2_shuffled");
endtask

task automatic test_filtering();
    fill_pattern(1, 4);
    // Rejected words follow the real one so a leak would overwrite it
    for (int pos = 0; pos < `CSR_SEQ_WIDTH; pos++) begin
        send_lane_word(1, pos, 0, BUF_ENGINE_SETUP);
        drive_response(BUF_KERNEL_DATA, 16'(16 + pos), 4'd0, ~lane_words[1][pos]);
        drive_response(BUF_CU_SETUP, 16'(64 + pos * 3), 4'd0, 32'hBAD0_0000 | pos);
        if (pos % 4 == 0)
            drive_response(BUF_INVALID, 16'(16 + pos), 4'd0, 32'hFFFF_FFFF);
    end
    end_burst();
    collect_records(4'b0010, "filtering");
    expect_idle(40, "filtering");
endtask

task automatic test_all_lanes_backpressure();
    for (int lane = 0; lane < `CSR_LANES; lane++) begin
        fill_pattern(lane, 5);
        for (int pos = 0; pos < `CSR_SEQ_WIDTH; pos++)
            send_lane_word(lane, pos, 1, BUF_CU_SETUP);
    end
    end_burst();
    repeat (100) @(posedge ap_clk);
    @(negedge ap_clk);
    check_value("all_lanes_backpressure", 1, config_out.valid);
    collect_records(4'b1111, "all_lanes_backpressure");
    expect_idle(20, "all_lanes_backpressure");
endtask

task automatic test_random_rounds();
    for (int round = 0; round < 2; round++) begin
        for (int pos = 0; pos < `CSR_SEQ_WIDTH; pos++) begin
            lane_words[1][pos] = random_word();
            lane_words[3][pos] = random_word();
        end
        for (int pos = 0; pos < `CSR_SEQ_WIDTH; pos++)
            send_lane_word(1, pos, 3, BUF_ENGINE_SETUP);
        for (int pos = 0; pos < `CSR_SEQ_WIDTH; pos++)
            send_lane_word(3, pos, 3, BUF_CU_SETUP);
        end_burst();
        collect_records(4'b1010, $sformatf("random_round_%0d", round));
    end
    expect_idle(20, "random_rounds");
endtask

`endif

// File: testbench/tb_csr_index_configure.sv
// ----------------------------------------------------------------------
// Testbench top for the stride index configurator. Generates clock and
// reset, instantiates the DUT and runs the directed tests in order.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "csr_index_macros.svh"

module tb_csr_index_configure import csr_index_pkg::*; ();

    logic             ap_clk;
    logic             areset_csr_index_generator;
    memory_response_t response;
    logic             in_prog_full;
    config_record_t   config_out;
    logic             config_rd_en;

    csr_index_configure_top i_csr_index_configure_top (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .response                   (response),
        .in_prog_full               (in_prog_full),
        .config_out                 (config_out),
        .config_rd_en               (config_rd_en)
    );

    // 8 ns period
    initial ap_clk = 1'b0;
    always #4 ap_clk = ~ap_clk;

    `include "tb_csr_index_tasks.svh"

// ----------------------------------------------------------------------
// Test sequence
// ----------------------------------------------------------------------
    initial begin
        response                   = '0;
        config_rd_en               = 1'b0;
        areset_csr_index_generator = 1'b1;
        repeat (16) @(posedge ap_clk);
        areset_csr_index_generator <= 1'b0;

        test_reset_idle();
        test_lane0_in_order();
        test_lane2_shuffled();
        test_filtering();
        test_all_lanes_backpressure();
        test_random_rounds();

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+src
+incdir+testbench
src/csr_index_pkg.sv
src/sync_fifo.sv
src/config_response_dispatcher.sv
src/config_word_capture.sv
src/config_collector.sv
src/csr_index_configure_top.sv
testbench/tb_csr_index_configure.sv

// File: Makefile
# Verilator build and run for the stride index configurator testbench.
# Any variable below can be overridden, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_csr_index_configure
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(wildcard src/*.sv src/*.svh testbench/*.sv testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "Testbench passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
